/* logic/ioBridge_macros.svh */
`ifndef IOBRIDGE_MACROS_SVH
`define IOBRIDGE_MACROS_SVH

// ****************************************
// bus widths
// ****************************************
`define IOB_ADDR_W 16 // word address on both buses.
`define IOB_DATA_W 16
`define IOB_SEL_W 2 // lower and upper byte lane.

// ****************************************
// post queue
// ****************************************
`define IOB_QUEUE_DEPTH 2 // two levels of queued requests.

// writes with this address bit set are acknowledged before the I/O cycle runs.
`define IOB_POSTED_BIT 15

`endif

/* logic/ioBridgePkg.sv */
`default_nettype none

`include "ioBridge_macros.svh"

package ioBridgePkg;

	// ****************************************
	// vectors
	// ****************************************
	typedef logic [`IOB_ADDR_W-1:0] ioAddrT; // word address.
	typedef logic [`IOB_DATA_W-1:0] ioDataT;
	typedef logic [`IOB_SEL_W-1:0] ioSelT; // bit 0 is the lower byte.

	// ****************************************
	// state machines
	// ****************************************
	typedef enum logic [1:0] {
		hostIdle, // waiting for a host strobe.
		hostPush, // request offered to the queue.
		hostWait, // waiting for the I/O completion.
		hostDone // answer is on the host bus.
	} hostStateT;

	typedef enum logic [1:0] {
		mstIdle, // ready for the next queued request.
		mstCycle, // I/O cycle in progress.
		mstDone // one cycle of recovery.
	} masterStateT;

endpackage

`default_nettype wire

/* logic/ioReqIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface ioReqIf
	import ioBridgePkg::*;
();

	logic valid; // request is on offer.
	logic ready; // receiver takes it on this edge.
	ioAddrT addr;
	ioDataT data; // write data, unused by reads.
	ioSelT sel;
	logic we;
	logic posted; // no completion is returned for this request.

	modport push (
		output valid,
		output addr,
		output data,
		output sel,
		output we,
		output posted,
		input ready
	);

	modport pop (
		input valid,
		input addr,
		input data,
		input sel,
		input we,
		input posted,
		output ready
	);

endinterface

`default_nettype wire

/* logic/ioHostSlave.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ioBridge_macros.svh"

module ioHostSlave
	import ioBridgePkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic hostCyc,
	input logic hostStb,
	input logic hostWe,
	input ioAddrT hostAdr,
	input ioSelT hostSel,
	input ioDataT hostDatW,
	output ioDataT hostDatR,
	output logic hostAck,
	output logic hostErr,
	ioReqIf.push enq,
	input logic rspValid,
	input logic rspErr,
	input ioDataT rspData
);

	hostStateT state;
	logic hostReq;
	logic pushDone;
	logic capture;
	logic rspTake;

	assign hostReq = hostCyc && hostStb; // a host cycle is addressed to the bridge.
	assign pushDone = enq.valid && enq.ready; // queue takes the request on this edge.
	assign capture = (state == hostIdle) && hostReq;
	assign rspTake = (state == hostWait) && rspValid;

	// ****************************************
	// control
	// ****************************************
	// The strobe is captured only in hostIdle, and hostDone keeps the machine away
	// from hostIdle until the host has seen its answer, so one strobe makes one request.
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= hostIdle;
			enq.valid <= 1'b0;
			hostAck <= 1'b0;
			hostErr <= 1'b0;
		end else begin
			hostAck <= 1'b0; // answers last a single cycle.
			hostErr <= 1'b0;
			case (state)
				hostIdle: begin
					if (hostReq) begin
						enq.valid <= 1'b1; // payload is loaded on the same edge.
						state <= hostPush;
					end
				end
				hostPush: begin
					if (pushDone) begin
						enq.valid <= 1'b0;
						if (enq.posted) begin
							hostAck <= 1'b1; // posted write ends once it is queued.
							state <= hostDone;
						end else begin
							state <= hostWait;
						end
					end
				end
				hostWait: begin
					if (rspValid) begin
						hostAck <= !rspErr;
						hostErr <= rspErr; // a failed I/O cycle ends the host cycle with err.
						state <= hostDone;
					end
				end
				hostDone: begin
					state <= hostIdle; // host drops its strobe on this edge.
				end
				default: begin
					state <= hostIdle;
				end
			endcase
		end
	end

	// ****************************************
	// payload
	// ****************************************
	always_ff @(posedge CLK) begin
		if (capture) begin
			enq.addr <= hostAdr;
			enq.data <= hostDatW;
			enq.sel <= hostSel; // byte lanes go through unchanged.
			enq.we <= hostWe;
			enq.posted <= hostWe && hostAdr[`IOB_POSTED_BIT]; // only writes can be posted.
		end
		if (rspTake) begin
			hostDatR <= rspData; // shown in the cycle of the ack.
		end
	end

endmodule

`default_nettype wire

/* logic/ioPostQueue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ioBridge_macros.svh"

module ioPostQueue
	import ioBridgePkg::*;
(
	input logic CLK,
	input logic rstN,
	ioReqIf.pop enq,
	ioReqIf.push deq
);

	localparam int PtrW = $clog2(`IOB_QUEUE_DEPTH);
	localparam int CntW = $clog2(`IOB_QUEUE_DEPTH + 1);

	ioAddrT addrMem [`IOB_QUEUE_DEPTH];
	ioDataT dataMem [`IOB_QUEUE_DEPTH];
	ioSelT selMem [`IOB_QUEUE_DEPTH];
	logic weMem [`IOB_QUEUE_DEPTH];
	logic postedMem [`IOB_QUEUE_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic push;
	logic pop;

	// advances a pointer around the ring.
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		nextPtr = (ptr == PtrW'(`IOB_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign enq.ready = (count < CntW'(`IOB_QUEUE_DEPTH)); // room for one more.
	assign deq.valid = (count != '0);
	assign push = enq.valid && enq.ready;
	assign pop = deq.valid && deq.ready;

	// the oldest entry is always on offer.
	assign deq.addr = addrMem[rdPtr];
	assign deq.data = dataMem[rdPtr];
	assign deq.sel = selMem[rdPtr];
	assign deq.we = weMem[rdPtr];
	assign deq.posted = postedMem[rdPtr];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither leave the fill level alone.
			endcase
		end
	end

	// Storage.
	always_ff @(posedge CLK) begin
		if (push) begin
			addrMem[wrPtr] <= enq.addr;
			dataMem[wrPtr] <= enq.data;
			selMem[wrPtr] <= enq.sel;
			weMem[wrPtr] <= enq.we;
			postedMem[wrPtr] <= enq.posted;
		end
	end

endmodule

`default_nettype wire

/* logic/ioBusMaster.sv */
`timescale 1ns/100ps
`default_nettype none

module ioBusMaster
	import ioBridgePkg::*;
(
	input logic CLK,
	input logic rstN,
	ioReqIf.pop deq,
	output logic ioCyc,
	output logic ioStb,
	output logic ioWe,
	output ioAddrT ioAdr,
	output ioSelT ioSel,
	output ioDataT ioDatW,
	input ioDataT ioDatR,
	input logic ioAck,
	input logic ioErr,
	output logic rspValid,
	output logic rspErr,
	output ioDataT rspData,
	output logic postedErr
);

	masterStateT state;
	logic curPosted; // the request in flight has no waiting host.
	logic take;
	logic ioResp;

	assign deq.ready = (state == mstIdle);
	assign take = deq.valid && deq.ready;
	assign ioResp = (state == mstCycle) && (ioAck || ioErr); // device ends the cycle.

	// ****************************************
	// cycle control
	// ****************************************
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= mstIdle;
			ioCyc <= 1'b0;
			ioStb <= 1'b0;
			rspValid <= 1'b0;
			postedErr <= 1'b0;
		end else begin
			rspValid <= 1'b0;
			case (state)
				mstIdle: begin
					if (take) begin
						ioCyc <= 1'b1;
						ioStb <= 1'b1;
						state <= mstCycle;
					end
				end
				mstCycle: begin
					if (ioResp) begin
						ioCyc <= 1'b0;
						ioStb <= 1'b0;
						rspValid <= !curPosted; // posted writes were answered already.
						if (curPosted && ioErr) begin
							postedErr <= 1'b1; // sticky until reset.
						end
						state <= mstDone;
					end
				end
				mstDone: begin
					state <= mstIdle;
				end
				default: begin
					state <= mstIdle;
				end
			endcase
		end
	end

	// Request and response registers.
	always_ff @(posedge CLK) begin
		if (take) begin
			ioWe <= deq.we;
			ioAdr <= deq.addr;
			ioSel <= deq.sel;
			ioDatW <= deq.data;
			curPosted <= deq.posted;
		end
		if (ioResp) begin
			rspData <= ioDatR;
			rspErr <= ioErr;
		end
	end

endmodule

`default_nettype wire

/* logic/ioBridge.sv */
`timescale 1ns/100ps
`default_nettype none

module ioBridge
	import ioBridgePkg::*;
(
	input logic CLK,
	input logic rstN,
	// ****************************************
	// host bus, Wishbone slave
	// ****************************************
	input logic hostCyc,
	input logic hostStb,
	input logic hostWe,
	input ioAddrT hostAdr,
	input ioSelT hostSel,
	input ioDataT hostDatW,
	output ioDataT hostDatR,
	output logic hostAck,
	output logic hostErr,
	// ****************************************
	// I/O bus, Wishbone master
	// ****************************************
	output logic ioCyc,
	output logic ioStb,
	output logic ioWe,
	output ioAddrT ioAdr,
	output ioSelT ioSel,
	output ioDataT ioDatW,
	input ioDataT ioDatR,
	input logic ioAck,
	input logic ioErr,
	output logic postedErr // a posted write saw err on the I/O bus.
);

	logic rspValid;
	logic rspErr;
	ioDataT rspData;

	ioReqIf enqIf(); // host slave to queue.
	ioReqIf deqIf(); // queue to I/O master.

	ioHostSlave u_ioHostSlave (
		.CLK(CLK),
		.rstN(rstN),
		.hostCyc(hostCyc),
		.hostStb(hostStb),
		.hostWe(hostWe),
		.hostAdr(hostAdr),
		.hostSel(hostSel),
		.hostDatW(hostDatW),
		.hostDatR(hostDatR),
		.hostAck(hostAck),
		.hostErr(hostErr),
		.enq(enqIf.push),
		.rspValid(rspValid),
		.rspErr(rspErr),
		.rspData(rspData)
	);

	ioPostQueue u_ioPostQueue (
		.CLK(CLK),
		.rstN(rstN),
		.enq(enqIf.pop),
		.deq(deqIf.push)
	);

	ioBusMaster u_ioBusMaster (
		.CLK(CLK),
		.rstN(rstN),
		.deq(deqIf.pop),
		.ioCyc(ioCyc),
		.ioStb(ioStb),
		.ioWe(ioWe),
		.ioAdr(ioAdr),
		.ioSel(ioSel),
		.ioDatW(ioDatW),
		.ioDatR(ioDatR),
		.ioAck(ioAck),
		.ioErr(ioErr),
		.rspValid(rspValid), // completions for non-posted requests only.
		.rspErr(rspErr),
		.rspData(rspData),
		.postedErr(postedErr)
	);

endmodule

`default_nettype wire

/* verification/ioBridge_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module ioBridgeAssertions (
	input logic CLK,
	input logic rstN,
	input logic hostStb,
	input logic hostAck,
	input logic hostErr,
	input logic ioStb,
	input logic ioAck,
	input logic ioErr
);

	// ****************************************
	// response rules
	// ****************************************
	hostRespOneKind: assert property (@(posedge CLK) disable iff (!rstN)
		!(hostAck && hostErr))
		else $error("host bus shows ack and err together.");

	ioRespOneKind: assert property (@(posedge CLK) disable iff (!rstN)
		!(ioAck && ioErr))
		else $error("I/O bus shows ack and err together.");

	// the master may not withdraw a strobe the device has not answered.
	ioStbHeld: assert property (@(posedge CLK) disable iff (!rstN)
		(ioStb && !ioAck && !ioErr) |=> ioStb)
		else $error("ioStb dropped before the device answered.");

	hostRespInCycle: assert property (@(posedge CLK) disable iff (!rstN)
		(hostAck || hostErr) |-> hostStb)
		else $error("host answer came without a host strobe.");

endmodule

bind ioBridge ioBridgeAssertions u_ioBridgeAssertions (
	.CLK(CLK),
	.rstN(rstN),
	.hostStb(hostStb),
	.hostAck(hostAck),
	.hostErr(hostErr),
	.ioStb(ioStb),
	.ioAck(ioAck),
	.ioErr(ioErr)
);

`default_nettype wire

/* verification/ioBridgeTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ioBridge_macros.svh"

module ioBridgeTb
	import ioBridgePkg::*;
();

	logic CLK;
	logic rstN;
	logic hostCyc;
	logic hostStb;
	logic hostWe;
	ioAddrT hostAdr;
	ioSelT hostSel;
	ioDataT hostDatW;
	ioDataT hostDatR;
	logic hostAck;
	logic hostErr;
	logic ioCyc;
	logic ioStb;
	logic ioWe;
	ioAddrT ioAdr;
	ioSelT ioSel;
	ioDataT ioDatW;
	ioDataT ioDatR;
	logic ioAck;
	logic ioErr;
	logic postedErr;

	logic [7:0] opQ [$]; // one entry per line of the tests file.
	ioAddrT adrQ [$];
	ioDataT wdatQ [$];
	ioSelT selQ [$];
	int waitsQ [$];
	ioDataT expDataQ [$];
	logic expErrQ [$];
	int waitQ [$]; // wait states of issued operations in issue order.
	ioAddrT issueQ [$];
	ioAddrT logQ [$]; // addresses of the I/O cycles the device served.
	ioDataT devMem [0:255];
	int numOps = 0;
	int maxWait = 0;
	int doneCount = 0;
	int firstErrIdx = -1; // first posted write to an error address.
	bit testsLoaded = 1'b0;
	bit passed = 1'b0;
	bit failSeen = 1'b0;

	ioBridge u_ioBridge (
		.CLK(CLK),
		.rstN(rstN),
		.hostCyc(hostCyc),
		.hostStb(hostStb),
		.hostWe(hostWe),
		.hostAdr(hostAdr),
		.hostSel(hostSel),
		.hostDatW(hostDatW),
		.hostDatR(hostDatR),
		.hostAck(hostAck),
		.hostErr(hostErr),
		.ioCyc(ioCyc),
		.ioStb(ioStb),
		.ioWe(ioWe),
		.ioAdr(ioAdr),
		.ioSel(ioSel),
		.ioDatW(ioDatW),
		.ioDatR(ioDatR),
		.ioAck(ioAck),
		.ioErr(ioErr),
		.postedErr(postedErr)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ****************************************
	// failure reporting and compare tasks
	// ****************************************
	function void showFailure();
		$display("Test failed");
	endfunction

	task automatic endWithFailure();
		failSeen = 1'b1;
		showFailure();
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic checkData(input ioDataT got, input ioDataT exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %h, expected %h.", $time, what, got, exp);
			endWithFailure();
		end
	endtask

	task automatic checkAddr(input ioAddrT got, input ioAddrT exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %h, expected %h.", $time, what, got, exp);
			endWithFailure();
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b.", $time, what, got, exp);
			endWithFailure();
		end
	endtask

	// untouched words carry a pattern built from the full 8-bit index.
	function automatic ioDataT fillWord(input logic [7:0] idx);
		return {idx ^ 8'hA5, idx};
	endfunction

	task automatic loadTests();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		ioAddrT adr;
		ioDataT wdat;
		ioSelT sel;
		int waits;
		ioDataT expData;
		logic expErr;
		fd = $fopen("verification/ioBridge_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/ioBridge_tests.txt");
			endWithFailure();
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if ((n > 0) && (line.len() > 2) && (line[0] != "#")) begin
					n = $sscanf(line, "%c %h %h %h %d %h %h", op, adr, wdat, sel, waits,
						expData, expErr);
					if (n == 7) begin
						opQ.push_back(op);
						adrQ.push_back(adr);
						wdatQ.push_back(wdat);
						selQ.push_back(sel);
						waitsQ.push_back(waits);
						expDataQ.push_back(expData);
						expErrQ.push_back(expErr);
						maxWait = (waits > maxWait) ? waits : maxWait;
					end
				end
			end
			$fclose(fd);
			numOps = opQ.size();
		end
	endtask

	// ****************************************
	// host driver
	// ****************************************
	task automatic runOp(input int i);
		logic posted;
		posted = (opQ[i] == "W") && adrQ[i][`IOB_POSTED_BIT];
		if (posted && (adrQ[i][7:4] == 4'hE) && (firstErrIdx < 0)) begin
			firstErrIdx = i; // its I/O cycle will end in ioErr.
		end
		waitQ.push_back(waitsQ[i]);
		issueQ.push_back(adrQ[i]);
		@(posedge CLK);
		#1;
		hostCyc = 1'b1;
		hostStb = 1'b1;
		hostWe = (opQ[i] == "W");
		hostAdr = adrQ[i];
		hostSel = selQ[i];
		hostDatW = wdatQ[i];
		do @(negedge CLK); while (!hostAck && !hostErr);
		checkFlag(hostErr, expErrQ[i], "hostErr");
		checkFlag(hostAck, !expErrQ[i], "hostAck");
		if (posted) begin
			// a posted write is answered before the device has served it.
			checkFlag(doneCount > i, 1'b0, "posted write served before hostAck");
		end
		if ((opQ[i] == "R") && !expErrQ[i]) begin
			checkData(hostDatR, expDataQ[i], "hostDatR");
		end
		checkFlag(postedErr, (firstErrIdx >= 0) && (doneCount > firstErrIdx), "postedErr");
		@(posedge CLK);
		#1;
		hostCyc = 1'b0; // host ends the cycle after the edge that saw the answer.
		hostStb = 1'b0;
	endtask

	// ****************************************
	// I/O device model
	// ****************************************
	initial begin : deviceModel
		int waits;
		ioAck = 1'b0;
		ioErr = 1'b0;
		ioDatR = '0;
		for (int a = 0; a < 256; a++) begin
			devMem[a[7:0]] = fillWord(a[7:0]);
		end
		forever begin
			@(posedge CLK);
			#1;
			if (ioCyc && ioStb) begin
				logQ.push_back(ioAdr);
				waits = waitQ.pop_front();
				repeat (waits) begin
					@(posedge CLK);
					#1;
				end
				if (ioAdr[7:4] == 4'hE) begin
					ioErr = 1'b1; // the error window leaves memory alone.
				end else begin
					if (ioWe && ioSel[0]) begin
						devMem[ioAdr[7:0]][7:0] = ioDatW[7:0];
					end
					if (ioWe && ioSel[1]) begin
						devMem[ioAdr[7:0]][15:8] = ioDatW[15:8];
					end
					ioDatR = devMem[ioAdr[7:0]];
					ioAck = 1'b1;
				end
				@(posedge CLK);
				#1;
				ioAck = 1'b0;
				ioErr = 1'b0;
				doneCount++;
			end
		end
	end

	initial begin : watchdog
		wait (testsLoaded);
		#(numOps * (maxWait + 20) * 10);
		$display("watchdog expired before all host operations finished");
		endWithFailure();
	end

	initial begin : mainFlow
		int gap;
		void'($urandom(32'h2718));
		rstN = 1'b0;
		hostCyc = 1'b0;
		hostStb = 1'b0;
		hostWe = 1'b0;
		hostAdr = '0;
		hostSel = '0;
		hostDatW = '0;
		loadTests();
		testsLoaded = 1'b1;
		repeat (3) @(posedge CLK);
		#1;
		rstN = 1'b1;
		for (int i = 0; i < numOps; i++) begin
			gap = $urandom % 4; // idle cycles between host operations.
			repeat (gap) @(posedge CLK);
			runOp(i);
		end
		while (doneCount < numOps) @(posedge CLK);
		@(negedge CLK);
		if (logQ.size() != issueQ.size()) begin
			$display("device served %0d I/O cycles for %0d host operations",
				logQ.size(), issueQ.size());
			endWithFailure();
		end else begin
			for (int i = 0; i < logQ.size(); i++) begin
				checkAddr(logQ[i], issueQ[i], "I/O cycle address");
			end
			checkFlag(postedErr, firstErrIdx >= 0, "postedErr at end");
			passed = 1'b1;
			$display("Test completed successfully");
			$finish;
		end
	end

	final begin
		if (!passed && !failSeen) begin
			showFailure(); // run stopped by an assertion or the simulator.
		end
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/ioBridgePkg.sv
logic/ioReqIf.sv
logic/ioHostSlave.sv
logic/ioPostQueue.sv
logic/ioBusMaster.sv
logic/ioBridge.sv
verification/ioBridge_assertions.sv
verification/ioBridgeTb.sv

/* run.sh */
#!/bin/sh
# Builds the bridge and its testbench with Verilator, runs it and searches the log.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f files.f --top-module ioBridgeTb -o ioBridgeSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/ioBridgeSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation ended with status $simStatus"
	exit 1
fi

if grep -qx "Test completed successfully" "$logFile"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* verification/ioBridge_tests.txt */
# op addr wdata sel waits expdata experr
# op is R or W; addr, wdata, sel, expdata and experr in hex; waits in decimal.
W 8010 1234 3 6 0000 0
R 8010 0000 3 2 1234 0
W 0020 abcd 3 3 0000 0
R 0020 0000 3 0 abcd 0
R 0042 0000 3 1 e742 0
R 00e0 0000 3 2 0000 1
W 00e1 5555 3 1 0000 1
W 8030 0f0f 3 4 0000 0
W 8031 1111 3 8 0000 0
W 8032 2222 3 8 0000 0
R 8030 0000 3 0 0f0f 0
R 8031 0000 3 1 1111 0
R 8032 0000 3 0 2222 0
W 80e5 dead 3 2 0000 0
R 0020 0000 3 1 abcd 0
W 0050 12ab 1 2 0000 0
R 0050 0000 3 0 f5ab 0
W 8060 cd34 2 3 0000 0
R 0060 0000 3 1 cd60 0
W 8010 7777 3 0 0000 0
R 0010 0000 3 0 7777 0
